/* logic/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ------------------------------------------------------------
// Memory geometry
// ------------------------------------------------------------

// Word address into the on-chip store
`define MEM_AW 12

// One 16-bit word, two byte lanes
`define MEM_DW 16

// Byte address from the I/O controller, bit 0 picks the lane
`define DL_AW (`MEM_AW + 1)

// ------------------------------------------------------------
// Joystick shift chain
// ------------------------------------------------------------

// Sample cycles per half period of the chain clock
`define JOY_DIV 4

// Bits shifted out of the chain per scan
`define JOY_BITS 16

`endif

/* logic/board_pkg.sv */
`include "board_macros.svh"

package board_pkg;

    // One joystick, active low
    // 0 right, 1 left, 2 down, 3 up, 4 fire1, 5 fire2
    typedef logic [5:0] joy_t;

    // Raw bits of one complete chain scan
    typedef logic [`JOY_BITS-1:0] joy_chain_t;

    // Byte address on the download port
    typedef logic [`DL_AW-1:0] dl_addr_t;

endpackage

/* logic/mem_pkg.sv */
`include "board_macros.svh"

package mem_pkg;

    // Word address into the store
    typedef logic [`MEM_AW-1:0] mem_addr_t;

    // Data word
    typedef logic [`MEM_DW-1:0] mem_data_t;

    // Byte write enables, bit 0 is the low byte
    typedef logic [1:0] mem_mask_t;

    // Arbiter sequence for a single access
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_DATA
    } arb_state_t;

endpackage

/* logic/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;
    import mem_pkg::*;

    // Request side, held stable until ack
    logic      req;
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
    mem_mask_t mask;

    // Response side
    // ack is one cycle, dok follows one cycle later with rdata
    logic      ack;
    logic      dok;
    mem_data_t rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        output mask,
        input  ack,
        input  dok,
        input  rdata
    );

    modport server (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  mask,
        output ack,
        output dok,
        output rdata
    );

endinterface

/* logic/joy_serial_reader.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module joy_serial_reader (
    input  logic              sample,
    input  logic              rst_i,
    input  logic              joy_data_i,
    output logic              joy_clk_o,
    output logic              joy_load_o,
    output board_pkg::joy_t   joy1_o,
    output board_pkg::joy_t   joy2_o
);
    import board_pkg::*;

    localparam int DIV_W = $clog2(`JOY_DIV);
    localparam int BIT_W = $clog2(`JOY_BITS);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             div_end;
    logic             last_bit;
    joy_chain_t       chain;

    // ------------------------------------------------------------
    // Phase pacing
    // ------------------------------------------------------------

    assign div_end  = div_cnt == DIV_W'(`JOY_DIV - 1);
    assign last_bit = bit_cnt == BIT_W'(`JOY_BITS - 1);

    // Load phase, then 16 clock pulses of one high and one low phase each
    always_ff @(posedge sample) begin
        if (rst_i) begin
            div_cnt    <= '0;
            // Start on the final bit so the first period opens a load
            bit_cnt    <= '1;
            joy_clk_o  <= 1'b0;
            joy_load_o <= 1'b1;
            chain      <= '1;
            joy1_o     <= '1;
            joy2_o     <= '1;
        end else begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;
            if (div_end) begin
                if (!joy_load_o) begin
                    // Bit 0 is on the line once the chain has loaded
                    joy_load_o <= 1'b1;
                    joy_clk_o  <= 1'b1;
                    chain      <= {joy_data_i, chain[`JOY_BITS-1:1]};
                end else if (joy_clk_o) begin
                    joy_clk_o <= 1'b0;
                end else if (last_bit) begin
                    // Scan complete, publish both sticks together
                    joy_load_o <= 1'b0;
                    bit_cnt    <= '0;
                    joy1_o     <= chain[5:0];
                    joy2_o     <= chain[13:8];
                end else begin
                    // Sample just before the next rising edge shifts the chain
                    joy_clk_o <= 1'b1;
                    bit_cnt   <= bit_cnt + 1'b1;
                    chain     <= {joy_data_i, chain[`JOY_BITS-1:1]};
                end
            end
        end
    end

endmodule

/* logic/rom_loader.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module rom_loader (
    input  logic                sample,
    input  logic                rst_i,
    input  logic                downloading_i,
    input  board_pkg::dl_addr_t ioctl_addr_i,
    input  logic [7:0]          ioctl_dout_i,
    input  logic                ioctl_wr_i,
    output logic                game_rst_o,
    mem_port_if.requester       prog
);

    logic wr_take;
    logic pending;

    // Byte writes only count while the download window is open
    assign wr_take = ioctl_wr_i && downloading_i;

    // ------------------------------------------------------------
    // Request control
    // ------------------------------------------------------------

    always_ff @(posedge sample) begin
        if (rst_i) begin
            prog.req   <= 1'b0;
            prog.we    <= 1'b0;
            pending    <= 1'b0;
            game_rst_o <= 1'b1;
        end else begin
            if (wr_take) begin
                prog.req <= 1'b1;
                prog.we  <= 1'b1;
            end else if (prog.ack) begin
                prog.req <= 1'b0;
                prog.we  <= 1'b0;
            end
            // Cleared once the store reports the write done
            if (wr_take) begin
                pending <= 1'b1;
            end else if (prog.dok) begin
                pending <= 1'b0;
            end
            game_rst_o <= downloading_i | pending;
        end
    end

    // Word fields, byte copied to both lanes and masked by address bit 0
    always_ff @(posedge sample) begin
        if (wr_take) begin
            prog.addr  <= ioctl_addr_i[`DL_AW-1:1];
            prog.wdata <= {2{ioctl_dout_i}};
            prog.mask  <= ioctl_addr_i[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

/* logic/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter (
    input  logic                sample,
    input  logic                rst_i,
    input  logic                downloading_i,
    mem_port_if.server          prog,
    mem_port_if.server          ba0,
    mem_port_if.server          ba1,
    output logic                mem_we_o,
    output mem_pkg::mem_addr_t  mem_addr_o,
    output mem_pkg::mem_data_t  mem_wdata_o,
    output mem_pkg::mem_mask_t  mem_mask_o,
    input  mem_pkg::mem_data_t  mem_rdata_i
);
    import mem_pkg::*;

    localparam logic [1:0] SEL_PROG = 2'd0;
    localparam logic [1:0] SEL_BA0  = 2'd1;
    localparam logic [1:0] SEL_BA1  = 2'd2;

    arb_state_t state;
    logic [1:0] win;
    logic       sel_we;
    logic       in_access;
    logic       in_data;

    // ------------------------------------------------------------
    // Grant sequence
    // ------------------------------------------------------------

    always_ff @(posedge sample) begin
        if (rst_i) begin
            state <= ARB_IDLE;
            win   <= SEL_PROG;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Loader first, game banks locked out during download
                    if (prog.req) begin
                        win   <= SEL_PROG;
                        state <= ARB_ACCESS;
                    end else if (!downloading_i && ba0.req) begin
                        win   <= SEL_BA0;
                        state <= ARB_ACCESS;
                    end else if (!downloading_i && ba1.req) begin
                        win   <= SEL_BA1;
                        state <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: begin
                    state <= ARB_DATA;
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    assign in_access = state == ARB_ACCESS;
    assign in_data   = state == ARB_DATA;

    // Store side follows the held winner
    always_comb begin
        case (win)
            SEL_BA0: begin
                sel_we      = ba0.we;
                mem_addr_o  = ba0.addr;
                mem_wdata_o = ba0.wdata;
                mem_mask_o  = ba0.mask;
            end
            SEL_BA1: begin
                sel_we      = ba1.we;
                mem_addr_o  = ba1.addr;
                mem_wdata_o = ba1.wdata;
                mem_mask_o  = ba1.mask;
            end
            default: begin
                sel_we      = prog.we;
                mem_addr_o  = prog.addr;
                mem_wdata_o = prog.wdata;
                mem_mask_o  = prog.mask;
            end
        endcase
    end

    assign mem_we_o = in_access && sel_we;

    // ------------------------------------------------------------
    // Responses, winner only
    // ------------------------------------------------------------

    assign prog.ack   = in_access && (win == SEL_PROG);
    assign ba0.ack    = in_access && (win == SEL_BA0);
    assign ba1.ack    = in_access && (win == SEL_BA1);

    assign prog.dok   = in_data && (win == SEL_PROG);
    assign ba0.dok    = in_data && (win == SEL_BA0);
    assign ba1.dok    = in_data && (win == SEL_BA1);

    assign prog.rdata = prog.dok ? mem_rdata_i : '0;
    assign ba0.rdata  = ba0.dok ? mem_rdata_i : '0;
    assign ba1.rdata  = ba1.dok ? mem_rdata_i : '0;

endmodule

/* logic/rom_store.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module rom_store (
    input  logic               sample,
    input  logic               we_i,
    input  mem_pkg::mem_addr_t addr_i,
    input  mem_pkg::mem_data_t wdata_i,
    input  mem_pkg::mem_mask_t mask_i,
    output mem_pkg::mem_data_t rdata_o
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** `MEM_AW;

    // Stand-in for the SDRAM, contents undefined until loaded
    mem_data_t mem [DEPTH];

    // ------------------------------------------------------------
    // Byte lane writes
    // ------------------------------------------------------------

    always_ff @(posedge sample) begin
        if (we_i) begin
            for (int b = 0; b < 2; b++) begin
                if (mask_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Registered read
    // ------------------------------------------------------------

    // Data shows up the cycle after the access, old word on a write
    always_ff @(posedge sample) begin
        rdata_o <= mem[addr_i];
    end

endmodule

/* logic/arcade_board_top.sv */
`timescale 1ns/1ps

module arcade_board_top (
    input  logic                sample,
    input  logic                rst_i,
    // Joystick chain
    input  logic                joy_data_i,
    output logic                joy_clk_o,
    output logic                joy_load_o,
    output board_pkg::joy_t     joy1_o,
    output board_pkg::joy_t     joy2_o,
    // ROM download
    input  logic                downloading_i,
    input  board_pkg::dl_addr_t ioctl_addr_i,
    input  logic [7:0]          ioctl_dout_i,
    input  logic                ioctl_wr_i,
    output logic                game_rst_o,
    // Game bank 0
    input  logic                ba0_rd_i,
    input  mem_pkg::mem_addr_t  ba0_addr_i,
    output logic                ba0_ack_o,
    output logic                ba0_dok_o,
    output mem_pkg::mem_data_t  ba0_data_o,
    // Game bank 1
    input  logic                ba1_rd_i,
    input  mem_pkg::mem_addr_t  ba1_addr_i,
    output logic                ba1_ack_o,
    output logic                ba1_dok_o,
    output mem_pkg::mem_data_t  ba1_data_o
);
    import mem_pkg::*;

    logic      mem_we;
    mem_addr_t mem_addr;
    mem_data_t mem_wdata;
    mem_mask_t mem_mask;
    mem_data_t mem_rdata;

    mem_port_if prog_port ();
    mem_port_if ba0_port ();
    mem_port_if ba1_port ();

    // ------------------------------------------------------------
    // Game banks, read only
    // ------------------------------------------------------------

    assign ba0_port.req   = ba0_rd_i;
    assign ba0_port.we    = 1'b0;
    assign ba0_port.addr  = ba0_addr_i;
    assign ba0_port.wdata = '0;
    assign ba0_port.mask  = '0;
    assign ba0_ack_o      = ba0_port.ack;
    assign ba0_dok_o      = ba0_port.dok;
    assign ba0_data_o     = ba0_port.rdata;

    assign ba1_port.req   = ba1_rd_i;
    assign ba1_port.we    = 1'b0;
    assign ba1_port.addr  = ba1_addr_i;
    assign ba1_port.wdata = '0;
    assign ba1_port.mask  = '0;
    assign ba1_ack_o      = ba1_port.ack;
    assign ba1_dok_o      = ba1_port.dok;
    assign ba1_data_o     = ba1_port.rdata;

    joy_serial_reader joy_serial_reader_i (
        .sample     ( sample     ),
        .rst_i      ( rst_i      ),
        .joy_data_i ( joy_data_i ),
        .joy_clk_o  ( joy_clk_o  ),
        .joy_load_o ( joy_load_o ),
        .joy1_o     ( joy1_o     ),
        .joy2_o     ( joy2_o     )
    );

    rom_loader rom_loader_i (
        .sample        ( sample        ),
        .rst_i         ( rst_i         ),
        .downloading_i ( downloading_i ),
        .ioctl_addr_i  ( ioctl_addr_i  ),
        .ioctl_dout_i  ( ioctl_dout_i  ),
        .ioctl_wr_i    ( ioctl_wr_i    ),
        .game_rst_o    ( game_rst_o    ),
        .prog          ( prog_port     )
    );

    bank_arbiter bank_arbiter_i (
        .sample        ( sample        ),
        .rst_i         ( rst_i         ),
        .downloading_i ( downloading_i ),
        .prog          ( prog_port     ),
        .ba0           ( ba0_port      ),
        .ba1           ( ba1_port      ),
        .mem_we_o      ( mem_we        ),
        .mem_addr_o    ( mem_addr      ),
        .mem_wdata_o   ( mem_wdata     ),
        .mem_mask_o    ( mem_mask      ),
        .mem_rdata_i   ( mem_rdata     )
    );

    rom_store rom_store_i (
        .sample  ( sample    ),
        .we_i    ( mem_we    ),
        .addr_i  ( mem_addr  ),
        .wdata_i ( mem_wdata ),
        .mask_i  ( mem_mask  ),
        .rdata_o ( mem_rdata )
    );

endmodule

/* tests/arcade_board_sva.sv */
`timescale 1ns/1ps

module arcade_board_sva (
    input logic sample,
    input logic rst_i,
    input logic downloading_i,
    input logic prog_ack,
    input logic prog_dok,
    input logic ba0_ack,
    input logic ba0_dok,
    input logic ba1_ack,
    input logic ba1_dok,
    input logic joy_clk,
    input logic joy_load
);

    // ------------------------------------------------------------
    // Arbiter responses
    // ------------------------------------------------------------

    single_ack: assert property (@(posedge sample) disable iff (rst_i)
        $onehot0({prog_ack, ba0_ack, ba1_ack}))
        else $error("ack high on more than one port");

    prog_dok_after_ack: assert property (@(posedge sample) disable iff (rst_i)
        prog_dok |-> $past(prog_ack))
        else $error("prog dok without ack one cycle before");

    ba0_dok_after_ack: assert property (@(posedge sample) disable iff (rst_i)
        ba0_dok |-> $past(ba0_ack))
        else $error("bank 0 dok without ack one cycle before");

    ba1_dok_after_ack: assert property (@(posedge sample) disable iff (rst_i)
        ba1_dok |-> $past(ba1_ack))
        else $error("bank 1 dok without ack one cycle before");

    // Grant decision uses the level seen at the grant edge
    bank_locked_out: assert property (@(posedge sample) disable iff (rst_i)
        (ba0_ack || ba1_ack) |-> !$past(downloading_i))
        else $error("bank ack while downloading");

    // ------------------------------------------------------------
    // Joystick chain
    // ------------------------------------------------------------

    joy_clk_quiet: assert property (@(posedge sample) disable iff (rst_i)
        !joy_load |-> !joy_clk)
        else $error("joy_clk high during load");

endmodule

bind bank_arbiter arcade_board_sva arbiter_sva_i (
    .sample        ( sample        ),
    .rst_i         ( rst_i         ),
    .downloading_i ( downloading_i ),
    .prog_ack      ( prog.ack      ),
    .prog_dok      ( prog.dok      ),
    .ba0_ack       ( ba0.ack       ),
    .ba0_dok       ( ba0.dok       ),
    .ba1_ack       ( ba1.ack       ),
    .ba1_dok       ( ba1.dok       ),
    .joy_clk       ( 1'b0          ),
    .joy_load      ( 1'b1          )
);

bind joy_serial_reader arcade_board_sva reader_sva_i (
    .sample        ( sample     ),
    .rst_i         ( rst_i      ),
    .downloading_i ( 1'b0       ),
    .prog_ack      ( 1'b0       ),
    .prog_dok      ( 1'b0       ),
    .ba0_ack       ( 1'b0       ),
    .ba0_dok       ( 1'b0       ),
    .ba1_ack       ( 1'b0       ),
    .ba1_dok       ( 1'b0       ),
    .joy_clk       ( joy_clk_o  ),
    .joy_load      ( joy_load_o )
);

/* tests/arcade_board_tb.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module arcade_board_tb;
    import board_pkg::*;
    import mem_pkg::*;

    // About 600 cycles of stimulus in total, limit well above that
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int NUM_BYTES      = 32;
    localparam int WRITE_GAP      = 6;
    localparam int DL_WORDS       = 2 ** `DL_AW;

    logic       sample;
    logic       rst_i;
    logic       joy_data_i;
    logic       joy_clk_o;
    logic       joy_load_o;
    joy_t       joy1_o;
    joy_t       joy2_o;
    logic       downloading_i;
    dl_addr_t   ioctl_addr_i;
    logic [7:0] ioctl_dout_i;
    logic       ioctl_wr_i;
    logic       game_rst_o;
    logic       ba0_rd_i;
    mem_addr_t  ba0_addr_i;
    logic       ba0_ack_o;
    logic       ba0_dok_o;
    mem_data_t  ba0_data_o;
    logic       ba1_rd_i;
    mem_addr_t  ba1_addr_i;
    logic       ba1_ack_o;
    logic       ba1_dok_o;
    mem_data_t  ba1_data_o;

    logic [31:0] rng_state = 32'd57;
    int          cycles = 0;
    joy_chain_t  chain_word = '1;
    joy_chain_t  chain_shift = '1;
    logic        joy_clk_q = 1'b0;
    logic [7:0]  ref_byte [DL_WORDS];
    logic        ref_set [DL_WORDS];
    dl_addr_t    wr_addrs [NUM_BYTES];

    arcade_board_top arcade_board_top_i (.*);

    initial begin
        sample = 1'b0;
        forever #4 sample = ~sample;
    end

    // ------------------------------------------------------------
    // Joystick chain model
    // ------------------------------------------------------------

    // Parallel load while load is low, shift once after each clock rise
    always @(negedge sample) begin
        if (!joy_load_o) begin
            chain_shift <= chain_word;
        end else if (joy_clk_o && !joy_clk_q) begin
            chain_shift <= chain_shift >> 1;
        end
        joy_clk_q <= joy_clk_o;
    end

    assign joy_data_i = chain_shift[0];

    always @(posedge sample) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout, no progress after %0d cycles", cycles));
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic bank_ack(input int bank);
        return (bank == 0) ? ba0_ack_o : ba1_ack_o;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
            else fail_run($sformatf("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp));
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else fail_run(what);
    endtask

    // One cycle of the download window, game held and banks locked out
    task automatic download_cycle();
        @(negedge sample);
        check_true("Game reset is low during the download", game_rst_o);
        check_true("Bank 0 was acked during the download", !ba0_ack_o);
    endtask

    task automatic write_byte(input dl_addr_t addr, input logic [7:0] data);
        ioctl_addr_i = addr;
        ioctl_dout_i = data;
        ioctl_wr_i   = 1'b1;
        download_cycle();
        ioctl_wr_i   = 1'b0;
        repeat (WRITE_GAP) download_cycle();
        ref_byte[addr] = data;
        ref_set[addr]  = 1'b1;
    endtask

    task automatic wait_ack(input int bank);
        while (!bank_ack(bank)) @(negedge sample);
    endtask

    // Drop the request after ack, data must arrive one cycle later
    task automatic finish_read(input int bank, output mem_data_t data);
        if (bank == 0) begin
            ba0_rd_i = 1'b0;
        end else begin
            ba1_rd_i = 1'b0;
        end
        @(negedge sample);
        check_true("No dok one cycle after ack", (bank == 0) ? ba0_dok_o : ba1_dok_o);
        data = (bank == 0) ? ba0_data_o : ba1_data_o;
    endtask

    task automatic read_bank(input int bank, input mem_addr_t addr, output mem_data_t data);
        if (bank == 0) begin
            ba0_addr_i = addr;
            ba0_rd_i   = 1'b1;
        end else begin
            ba1_addr_i = addr;
            ba1_rd_i   = 1'b1;
        end
        wait_ack(bank);
        finish_read(bank, data);
    endtask

    // Only lanes written during the download are compared
    task automatic expect_word(input string name, input mem_addr_t waddr, input mem_data_t got);
        mem_data_t exp;
        mem_data_t keep;
        dl_addr_t  lo;
        dl_addr_t  hi;
        lo   = {waddr, 1'b0};
        hi   = {waddr, 1'b1};
        exp  = '0;
        keep = '0;
        if (ref_set[lo]) begin
            exp[7:0]  = ref_byte[lo];
            keep[7:0] = 8'hff;
        end
        if (ref_set[hi]) begin
            exp[15:8]  = ref_byte[hi];
            keep[15:8] = 8'hff;
        end
        check_value(name, got & keep, exp);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        logic [31:0] r;
        mem_data_t   got;
        mem_addr_t   a0;
        mem_addr_t   a1;
        rst_i         = 1'b1;
        downloading_i = 1'b0;
        ioctl_addr_i  = '0;
        ioctl_dout_i  = '0;
        ioctl_wr_i    = 1'b0;
        ba0_rd_i      = 1'b0;
        ba0_addr_i    = '0;
        ba1_rd_i      = 1'b0;
        ba1_addr_i    = '0;
        for (int i = 0; i < DL_WORDS; i++) begin
            ref_set[i] = 1'b0;
        end

        repeat (16) @(negedge sample);
        check_true("Game reset is low under reset", game_rst_o);
        check_value("joy1_o", 16'(joy1_o), 16'h003f);
        check_value("joy2_o", 16'(joy2_o), 16'h003f);
        check_true("Bank ack or dok is high under reset",
                   !(ba0_ack_o || ba0_dok_o || ba1_ack_o || ba1_dok_o));
        rst_i = 1'b0;

        // Second completed scan carries the new word only
        r = next_random();
        chain_word = r[15:0];
        repeat (2) @(negedge joy_load_o);
        @(negedge sample);
        check_value("joy1_o", 16'(joy1_o), 16'(chain_word[5:0]));
        check_value("joy2_o", 16'(joy2_o), 16'(chain_word[13:8]));

        downloading_i = 1'b1;
        download_cycle();
        for (int i = 0; i < NUM_BYTES; i++) begin
            r = next_random();
            // Odd writes fill the other lane of the word before
            if (i % 2 == 1) begin
                wr_addrs[i] = {wr_addrs[i-1][`DL_AW-1:1], ~wr_addrs[i-1][0]};
            end else begin
                wr_addrs[i] = r[`DL_AW-1:0];
            end
            write_byte(wr_addrs[i], r[23:16]);
            if (i == NUM_BYTES / 2) begin
                ba0_addr_i = wr_addrs[0][`DL_AW-1:1];
                ba0_rd_i   = 1'b1;
            end
        end
        downloading_i = 1'b0;
        @(negedge sample);
        check_true("Game reset still high after the download", !game_rst_o);
        wait_ack(0);
        finish_read(0, got);
        expect_word("ba0_data_o", wr_addrs[0][`DL_AW-1:1], got);

        for (int i = 0; i < NUM_BYTES; i++) begin
            read_bank(i % 2, wr_addrs[i][`DL_AW-1:1], got);
            expect_word((i % 2 == 0) ? "ba0_data_o" : "ba1_data_o",
                        wr_addrs[i][`DL_AW-1:1], got);
        end

        // Both banks in the same cycle
        r = next_random();
        a0 = wr_addrs[r[4:0]][`DL_AW-1:1];
        // Two entries apart is another pair of writes, so another word
        a1 = wr_addrs[r[4:0] ^ 5'd2][`DL_AW-1:1];
        ba0_addr_i = a0;
        ba1_addr_i = a1;
        ba0_rd_i   = 1'b1;
        ba1_rd_i   = 1'b1;
        while (!ba0_ack_o && !ba1_ack_o) @(negedge sample);
        check_true("Bank 1 was acked ahead of bank 0", ba0_ack_o && !ba1_ack_o);
        finish_read(0, got);
        expect_word("ba0_data_o", a0, got);
        wait_ack(1);
        finish_read(1, got);
        expect_word("ba1_data_o", a1, got);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
logic/board_pkg.sv
logic/mem_pkg.sv
logic/mem_port_if.sv
logic/joy_serial_reader.sv
logic/rom_loader.sv
logic/bank_arbiter.sv
logic/rom_store.sv
logic/arcade_board_top.sv
tests/arcade_board_sva.sv
tests/arcade_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the arcade board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/1ps -f files.f \
    --top-module arcade_board_tb -Mdir "$OBJ" -o arcade_board_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/arcade_board_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
